/* sources.f */
+incdir+include
design/mem_stage_pkg.sv
design/stage_reg.sv
design/store_align.sv
design/data_mem.sv
design/load_extend.sv
design/mem_stage.sv
testbench/mem_stage_checker.sv
testbench/tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mem_stage testbench with Verilator
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_mem_stage \
    --Mdir "$build_dir" -o tb_mem_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/tb_mem_stage" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "No errors" "$log_file"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* testbench/tb_mem_stage.sv */
`default_nettype none

`include "mem_stage_params.svh"

module tb_mem_stage;

    import mem_stage_pkg::*;

    // one table row holding stimulus plus the expected writeback
    typedef struct packed {
        logic                       valid;
        mem_op_e                    op;
        logic [`MEM_NB_DATA-1:0]    addr;
        logic [`MEM_NB_DATA-1:0]    data;
        logic [`MEM_REG_ADDR_W-1:0] rd;
        logic [`MEM_NB_DATA-1:0]    exp_result;
        logic                       exp_fault;
    } row_t;

    logic    clock_i;
    logic    reset_i;
    ex_mem_t ex_i;
    mem_wb_t wb_o;

    row_t    rows[$];
    // up to two expectations in flight
    mem_wb_t expected[$];

    int checks      = 0;
    int errors      = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    mem_stage u_mem_stage (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .ex_i(ex_i),
        .wb_o(wb_o)
    );

    // period 8
    initial begin
        clock_i = 1'b0;
        forever #4 clock_i = ~clock_i;
    end

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp_val,
                     act_val);
        end
    endtask

    task automatic add_row(input logic valid, input mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [4:0] rd,
                           input logic [31:0] exp_result, input logic exp_fault);
        row_t r;
        r = '{valid, op, addr, data, rd, exp_result, exp_fault};
        rows.push_back(r);
    endtask

    // oldest expectation against what wb_o holds now
    task automatic compare_wb();
        mem_wb_t exp_wb;
        exp_wb = expected.pop_front();
        check_value("wb_o.valid", 32'(exp_wb.valid), 32'(wb_o.valid));
        // bubble contents are don't care
        if (exp_wb.valid) begin
            check_value("wb_o.rd", 32'(exp_wb.rd), 32'(wb_o.rd));
            check_value("wb_o.result", exp_wb.result, wb_o.result);
            check_value("wb_o.fault", 32'(exp_wb.fault), 32'(wb_o.fault));
        end
    endtask

    task automatic fill_table();
        // loads right after reset see a cleared RAM
        add_row(1'b1, op_lw,   32'h0000_0000, 32'h0000_0000, 5'd1,  32'h0000_0000, 1'b0);
        add_row(1'b1, op_lw,   32'h0000_0100, 32'h0000_0000, 5'd2,  32'h0000_0000, 1'b0);
        add_row(1'b1, op_lw,   32'h0000_01fc, 32'h0000_0000, 5'd3,  32'h0000_0000, 1'b0);
        // store then load in the very next cycle
        add_row(1'b1, op_sw,   32'h0000_0010, 32'hdead_beef, 5'd4,  32'h0000_0000, 1'b0);
        add_row(1'b1, op_lw,   32'h0000_0010, 32'h0000_0000, 5'd5,  32'hdead_beef, 1'b0);
        // 0x214 wraps onto 0x014
        add_row(1'b1, op_sw,   32'h0000_0214, 32'h1234_5678, 5'd6,  32'h0000_0000, 1'b0);
        add_row(1'b1, op_lw,   32'h0000_0014, 32'h0000_0000, 5'd7,  32'h1234_5678, 1'b0);
        // partial stores merge into one word
        add_row(1'b1, op_sw,   32'h0000_0020, 32'h1122_3344, 5'd8,  32'h0000_0000, 1'b0);
        add_row(1'b1, op_sb,   32'h0000_0021, 32'hffff_ffaa, 5'd9,  32'h0000_0000, 1'b0);
        add_row(1'b1, op_sh,   32'h0000_0022, 32'h0000_beef, 5'd10, 32'h0000_0000, 1'b0);
        add_row(1'b1, op_lw,   32'h0000_0020, 32'h0000_0000, 5'd11, 32'hbeef_aa44, 1'b0);
        add_row(1'b1, op_sb,   32'h0000_0027, 32'h0000_00c3, 5'd12, 32'h0000_0000, 1'b0);
        add_row(1'b1, op_lw,   32'h0000_0024, 32'h0000_0000, 5'd13, 32'hc300_0000, 1'b0);
        // sign and zero extension
        add_row(1'b1, op_sw,   32'h0000_0030, 32'h80f0_7f85, 5'd14, 32'h0000_0000, 1'b0);
        add_row(1'b1, op_lb,   32'h0000_0030, 32'h0000_0000, 5'd15, 32'hffff_ff85, 1'b0);
        add_row(1'b1, op_lbu,  32'h0000_0030, 32'h0000_0000, 5'd16, 32'h0000_0085, 1'b0);
        add_row(1'b1, op_lb,   32'h0000_0031, 32'h0000_0000, 5'd17, 32'h0000_007f, 1'b0);
        add_row(1'b1, op_lb,   32'h0000_0033, 32'h0000_0000, 5'd18, 32'hffff_ff80, 1'b0);
        add_row(1'b1, op_lbu,  32'h0000_0032, 32'h0000_0000, 5'd19, 32'h0000_00f0, 1'b0);
        add_row(1'b1, op_lh,   32'h0000_0032, 32'h0000_0000, 5'd20, 32'hffff_80f0, 1'b0);
        add_row(1'b1, op_lhu,  32'h0000_0032, 32'h0000_0000, 5'd21, 32'h0000_80f0, 1'b0);
        add_row(1'b1, op_lh,   32'h0000_0030, 32'h0000_0000, 5'd22, 32'h0000_7f85, 1'b0);
        // misaligned accesses fault and return zero
        add_row(1'b1, op_lh,   32'h0000_0031, 32'h0000_0000, 5'd23, 32'h0000_0000, 1'b1);
        add_row(1'b1, op_lw,   32'h0000_0032, 32'h0000_0000, 5'd24, 32'h0000_0000, 1'b1);
        add_row(1'b1, op_lhu,  32'h0000_0033, 32'h0000_0000, 5'd25, 32'h0000_0000, 1'b1);
        add_row(1'b1, op_sh,   32'h0000_0033, 32'hffff_ffff, 5'd26, 32'h0000_0000, 1'b1);
        add_row(1'b1, op_sw,   32'h0000_0031, 32'hffff_ffff, 5'd27, 32'h0000_0000, 1'b1);
        // word must be untouched by the faulted stores
        add_row(1'b1, op_lw,   32'h0000_0030, 32'h0000_0000, 5'd28, 32'h80f0_7f85, 1'b0);
        // pass-through and bubble
        add_row(1'b1, op_none, 32'h1234_5678, 32'h0000_0000, 5'd29, 32'h1234_5678, 1'b0);
        add_row(1'b0, op_lw,   32'h0000_0030, 32'h0000_0000, 5'd30, 32'h0000_0000, 1'b0);
        add_row(1'b1, op_none, 32'hffff_ffff, 32'h0000_0000, 5'd31, 32'hffff_ffff, 1'b0);
        add_row(1'b1, op_lw,   32'h0000_0010, 32'h0000_0000, 5'd0,  32'hdead_beef, 1'b0);
    endtask

    initial begin
        reset_i <= 1'b1;
        ex_i    <= '0;
        fill_table();
        cycle_limit = rows.size() + 20;
        repeat (2) @(posedge clock_i);
        @(negedge clock_i);
        reset_i <= 1'b0;
        check_value("wb_o.valid", 32'h0, 32'(wb_o.valid));
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clock_i);
            // row driven two falling edges ago is now on wb_o
            if (expected.size() == 2) begin
                compare_wb();
            end
            ex_i <= '{valid: rows[i].valid, op: rows[i].op, addr: rows[i].addr,
                      store_data: rows[i].data, rd: rows[i].rd};
            expected.push_back('{valid: rows[i].valid, rd: rows[i].rd,
                                 result: rows[i].exp_result, fault: rows[i].exp_fault});
        end
        // drain the last two
        repeat (2) begin
            @(negedge clock_i);
            ex_i <= '0;
            compare_wb();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clock_i);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/mem_stage_checker.sv */
`default_nettype none

// port rules of mem_stage attached by the bind below
module mem_stage_checker (
    input logic                   clock_i,
    input logic                   reset_i,
    input mem_stage_pkg::ex_mem_t ex_i,
    input mem_stage_pkg::mem_wb_t wb_i
);

    // cycles since reset saturating at 2
    logic [1:0] run_cnt;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            run_cnt <= '0;
        end else if (run_cnt != 2'd2) begin
            run_cnt <= run_cnt + 2'd1;
        end
    end

    // wb register cleared by the reset edge
    a_idle_after_reset: assert property (@(posedge clock_i) $past(reset_i) |-> !wb_i.valid)
        else $error("wb valid high in the cycle after reset");

    // fixed two-edge latency once both registers are out of reset
    a_valid_latency: assert property (@(posedge clock_i)
        run_cnt == 2'd2 |-> wb_i.valid == $past(ex_i.valid, 2))
        else $error("wb valid does not follow ex valid two cycles later");

    // faulted entries carry no data
    a_fault_zero: assert property (@(posedge clock_i) disable iff (reset_i)
        wb_i.fault |-> wb_i.result == '0)
        else $error("fault set with nonzero result");

endmodule

bind mem_stage mem_stage_checker u_mem_stage_checker (
    .clock_i(clock_i),
    .reset_i(reset_i),
    .ex_i(ex_i),
    .wb_i(wb_o)
);

`default_nettype wire

/* design/mem_stage.sv */
`default_nettype none

`include "mem_stage_params.svh"

module mem_stage (
    input  logic                   clock_i,
    input  logic                   reset_i,
    input  mem_stage_pkg::ex_mem_t ex_i,
    output mem_stage_pkg::mem_wb_t wb_o
);

    import mem_stage_pkg::*;

    ex_mem_t                 ex_q;
    mem_wb_t                 wb_d;
    logic [`MEM_NB_DATA-1:0] wdata;
    logic [`MEM_NB_DATA-1:0] rdata;
    logic [3:0]              byte_en;
    logic                    misalign;
    logic                    is_store;
    logic                    mem_en;
    logic                    mem_write;

    // ram only runs for a valid load or store
    assign is_store  = ex_q.op inside {op_sb, op_sh, op_sw};
    assign mem_en    = ex_q.valid && (ex_q.op != op_none);
    // misaligned store leaves memory alone
    assign mem_write = is_store && !misalign;

    // entry from execute sampled on the rising edge
    stage_reg #(.payload_t(ex_mem_t)) u_ex_reg (
        .clock_i(clock_i), .reset_i(reset_i), .d_i(ex_i), .q_o(ex_q)
    );

    store_align u_store_align (
        .op_i(ex_q.op), .addr_lo_i(ex_q.addr[1:0]), .data_i(ex_q.store_data),
        .wdata_o(wdata), .byte_en_o(byte_en), .misalign_o(misalign)
    );

    // word index is bits 8..2 so byte addresses wrap at 512
    data_mem u_data_mem (
        .clock_i(clock_i), .reset_i(reset_i), .enable_i(mem_en),
        .word_addr_i(ex_q.addr[`MEM_WORD_ADDR_W+1:2]), .write_i(mem_write),
        .byte_en_i(byte_en), .wdata_i(wdata), .rdata_o(rdata)
    );

    load_extend u_load_extend (
        .entry_i(ex_q), .rdata_i(rdata), .misalign_i(misalign), .wb_o(wb_d)
    );

    // result held for writeback
    stage_reg #(.payload_t(mem_wb_t)) u_wb_reg (
        .clock_i(clock_i), .reset_i(reset_i), .d_i(wb_d), .q_o(wb_o)
    );

endmodule

`default_nettype wire

/* design/load_extend.sv */
`default_nettype none

`include "mem_stage_params.svh"

module load_extend (
    input  mem_stage_pkg::ex_mem_t  entry_i,
    input  logic [`MEM_NB_DATA-1:0] rdata_i,
    input  logic                    misalign_i,
    output mem_stage_pkg::mem_wb_t  wb_o
);

    import mem_stage_pkg::*;

    logic [1:0]              lane;
    logic [7:0]              byte_sel;
    logic [15:0]             half_sel;
    logic [`MEM_NB_DATA-1:0] result;

    assign lane = entry_i.addr[1:0];

    // addressed byte and half out of the read word
    always_comb begin
        case (lane)
            2'd0:    byte_sel = rdata_i[7:0];
            2'd1:    byte_sel = rdata_i[15:8];
            2'd2:    byte_sel = rdata_i[23:16];
            default: byte_sel = rdata_i[31:24];
        endcase
        half_sel = lane[1] ? rdata_i[31:16] : rdata_i[15:0];
    end

    always_comb begin
        case (entry_i.op)
            op_lb:   result = {{24{byte_sel[7]}}, byte_sel};
            op_lh:   result = {{16{half_sel[15]}}, half_sel};
            op_lw:   result = rdata_i;
            op_lbu:  result = {24'd0, byte_sel};
            op_lhu:  result = {16'd0, half_sel};
            // alu result goes on when there is no memory op
            op_none: result = entry_i.addr;
            // stores give nothing back
            default: result = '0;
        endcase
        // misaligned access returns zero
        if (misalign_i) begin
            result = '0;
        end
    end

    assign wb_o = '{valid: entry_i.valid, rd: entry_i.rd, result: result,
                    fault: entry_i.valid & misalign_i};

endmodule

`default_nettype wire

/* design/data_mem.sv */
`default_nettype none

`include "mem_stage_params.svh"

// word ram with byte lanes working on the falling edge
module data_mem (
    input  logic                        clock_i,
    input  logic                        reset_i,
    input  logic                        enable_i,
    input  logic [`MEM_WORD_ADDR_W-1:0] word_addr_i,
    input  logic                        write_i,
    input  logic [3:0]                  byte_en_i,
    input  logic [`MEM_NB_DATA-1:0]     wdata_i,
    output logic [`MEM_NB_DATA-1:0]     rdata_o
);

    logic [`MEM_NB_DATA-1:0] ram [`MEM_N_ELEMENTS];
    logic [`MEM_NB_DATA-1:0] rdata_q;

    assign rdata_o = rdata_q;

    // falling edge puts the access mid-cycle
    always_ff @(negedge clock_i) begin
        if (reset_i) begin
            // whole array cleared along with the read register
            for (int i = 0; i < `MEM_N_ELEMENTS; i++) begin
                ram[i] <= '0;
            end
            rdata_q <= '0;
        end else if (enable_i) begin
            if (write_i) begin
                // only the enabled lanes change
                for (int b = 0; b < 4; b++) begin
                    if (byte_en_i[b]) begin
                        ram[word_addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
            // read register loads on every enabled access
            rdata_q <= ram[word_addr_i];
        end
        // read register keeps its last word while disabled
    end

endmodule

`default_nettype wire

/* design/store_align.sv */
`default_nettype none

`include "mem_stage_params.svh"

module store_align (
    input  mem_stage_pkg::mem_op_e  op_i,
    input  logic [1:0]              addr_lo_i,
    input  logic [`MEM_NB_DATA-1:0] data_i,
    output logic [`MEM_NB_DATA-1:0] wdata_o,
    output logic [3:0]              byte_en_o,
    output logic                    misalign_o
);

    import mem_stage_pkg::*;

    // access size decoded from op
    logic size_byte;
    logic size_half;
    logic size_word;

    assign size_byte = (op_i == op_lb) || (op_i == op_lbu) || (op_i == op_sb);
    assign size_half = (op_i == op_lh) || (op_i == op_lhu) || (op_i == op_sh);
    assign size_word = (op_i == op_lw) || (op_i == op_sw);

    always_comb begin
        wdata_o    = data_i;
        byte_en_o  = 4'b0000;
        misalign_o = 1'b0;
        if (size_byte) begin
            // byte copied into all four lanes
            wdata_o   = {4{data_i[7:0]}};
            byte_en_o = 4'b0001 << addr_lo_i;
        end else if (size_half) begin
            // low half copied into both halves
            wdata_o    = {2{data_i[15:0]}};
            byte_en_o  = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            // odd address
            misalign_o = addr_lo_i[0];
        end else if (size_word) begin
            byte_en_o  = 4'b1111;
            // word must sit on a 4-byte boundary
            misalign_o = (addr_lo_i != 2'b00);
        end
    end

endmodule

`default_nettype wire

/* design/stage_reg.sv */
`default_nettype none

// one pipeline boundary
// payload type picked per instance
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock_i,
    input  logic     reset_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // whole payload goes to zero on reset and valid drops with it
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* design/mem_stage_pkg.sv */
`default_nettype none

`include "mem_stage_params.svh"

package mem_stage_pkg;

    // memory operation carried by each entry
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_e;

    // entry handed over by execute
    typedef struct packed {
        logic                       valid;
        mem_op_e                    op;
        // alu result used as byte address
        logic [`MEM_NB_DATA-1:0]    addr;
        logic [`MEM_NB_DATA-1:0]    store_data;
        logic [`MEM_REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    // entry handed to writeback
    typedef struct packed {
        logic                       valid;
        logic [`MEM_REG_ADDR_W-1:0] rd;
        logic [`MEM_NB_DATA-1:0]    result;
        // misaligned access seen
        logic                       fault;
    } mem_wb_t;

endpackage

`default_nettype wire

/* include/mem_stage_params.svh */
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// width of one RAM word and of the pipeline data path
`define MEM_NB_DATA 32

// RAM depth in words
`define MEM_N_ELEMENTS 128

// word index into the RAM taken from byte address bits [8:2]
`define MEM_WORD_ADDR_W 7

// destination register index
`define MEM_REG_ADDR_W 5

`endif
